//--- verilog.f
common/ex_pkg.sv
design/alu_unit.sv
mult/mult_unit.sv
complete/complete_buffer.sv
design/ex_stage.sv
test/ex_stage_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = ex_stage_tb
FILELIST = verilog.f

BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

    localparam int MULT_STAGES = 4;
    localparam int CDB_WIDTH   = 3;
    localparam int WAIT_LIMIT  = 200;

    logic                            clock = 1'b0;
    logic                            reset;
    logic                            clear;
    issue_packet_t [ISSUE_WIDTH-1:0] issue;
    cdb_packet_t   [CDB_WIDTH-1:0]   cdb;
    logic          [ISSUE_WIDTH-1:0] alu_free;
    logic          [ISSUE_WIDTH-1:0] mult_free;

    // scoreboard indexed by rob tag
    cdb_packet_t expect_q [ROB_LEN];
    bit          busy [ROB_LEN];
    bit          flushed [ROB_LEN];  // killed by clear, must never show up
    int          issued_at [ROB_LEN];
    int          latency [ROB_LEN];  // -1 when latency is not fixed

    int    cycle = 0;
    int    next_tag = 0;
    int    errors = 0;
    int    checks = 0;
    int    err_before;
    int    busy_cycles;
    int    nflushed;
    xlen_t edge_a [6];
    xlen_t edge_b [6];

    ex_stage #(
        .MULT_STAGES (MULT_STAGES),
        .CDB_WIDTH   (CDB_WIDTH)
    ) dut0 (
        .clock       (clock),
        .reset       (reset),
        .clear_i     (clear),
        .issue_i     (issue),
        .cdb_o       (cdb),
        .alu_free_o  (alu_free),
        .mult_free_o (mult_free)
    );

    always #50 clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    // expected result straight from the rv32im definitions
    function automatic xlen_t ref_result(input fu_op_e op, input xlen_t a, input xlen_t b);
        logic [4:0]      sh;
        longint          sa;
        longint          sb;
        longint          sp;
        longint unsigned ua;
        longint unsigned ub;
        longint unsigned up;
        sh = b[4:0];
        sa = $signed(a);
        sb = $signed(b);
        ua = {32'h0, a};
        ub = {32'h0, b};
        sp = sa * sb;
        up = ua * ub;
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLT:   return (a[31] != b[31]) ? {31'h0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
            OP_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            OP_SLL:   return a << sh;
            OP_SRL:   return a >> sh;
            OP_SRA:   return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0);
            OP_MUL:   return a * b;
            OP_MULH:  return sp[63:32];
            OP_MULHU: return up[63:32];
            default:  return 32'h0;
        endcase
    endfunction

    function automatic int alloc_tag();
        int t;
        for (int k = 0; k < ROB_LEN; k++) begin
            t = (next_tag + k) % ROB_LEN;
            if (!busy[t] && !flushed[t]) begin
                next_tag = (t + 1) % ROB_LEN;
                return t;
            end
        end
        return -1;
    endfunction

    function automatic int count_busy();
        int n;
        n = 0;
        for (int t = 0; t < ROB_LEN; t++) begin
            if (busy[t]) n++;
        end
        return n;
    endfunction

    function automatic bit tag_available();
        for (int t = 0; t < ROB_LEN; t++) begin
            if (!busy[t] && !flushed[t]) return 1'b1;
        end
        return 1'b0;
    endfunction

    // next drive point is 1 ns after the rising edge
    task automatic step();
        @(posedge clock);
        #1;
        issue = '0;
    endtask

    task automatic send(input int lane, input func_unit_e unit, input fu_op_e op,
                        input xlen_t a, input xlen_t b, input int lat);
        issue_packet_t p;
        int            t;
        t = alloc_tag();
        if (t < 0) begin
            $display("no free rob tag for a packet on lane %0d", lane);
            errors++;
        end else begin
            p.valid = 1'b1;
            p.unit  = unit;
            p.op    = op;
            p.tag   = tag_t'(t);
            p.opa   = a;
            p.opb   = b;
            p.npc   = $urandom;
            p.halt  = ($urandom_range(15, 0) == 0);
            issue[lane] = p;
            expect_q[t].valid = 1'b1;
            expect_q[t].tag   = p.tag;
            expect_q[t].value = ref_result(op, a, b);
            expect_q[t].npc   = p.npc;
            expect_q[t].halt  = p.halt;
            busy[t]      = 1'b1;
            issued_at[t] = cycle;
            latency[t]   = lat;
        end
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (count_busy() > 0 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (count_busy() > 0) begin
            $write("timeout in %s, tags that never came back:", what);
            for (int t = 0; t < ROB_LEN; t++) begin
                if (busy[t]) begin
                    $write(" %0d", t);
                    busy[t] = 1'b0;
                end
            end
            $display("");
            errors++;
        end
    endtask

    task automatic check_idle(input string where);
        logic [CDB_WIDTH-1:0] valids;
        for (int l = 0; l < CDB_WIDTH; l++) begin
            valids[l] = cdb[l].valid;
        end
        checks++;
        if (valids !== '0) begin
            $display("** Error: cdb_o valid %s: got %h, expected %h", where, valids, 0);
            errors++;
        end
        if (alu_free !== '1) begin
            $display("** Error: alu_free_o %s: got %h, expected %h", where, alu_free, 3'h7);
            errors++;
        end
        if (mult_free !== '1) begin
            $display("** Error: mult_free_o %s: got %h, expected %h", where, mult_free, 3'h7);
            errors++;
        end
    endtask

    // every lane tries to issue to a random unit, only free units get a packet
    task automatic random_load(input int ncycles);
        func_unit_e unit;
        fu_op_e     op;
        logic       free;
        for (int n = 0; n < ncycles; n++) begin
            if (alu_free !== '1 || mult_free !== '1) busy_cycles++;
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if ($urandom_range(7, 0) != 0 && tag_available()) begin
                    if ($urandom_range(1, 0) == 0) begin
                        unit = FU_ALU;
                        op   = fu_op_e'(4'($urandom_range(9, 0)));
                        free = alu_free[l];
                    end else begin
                        unit = FU_MULT;
                        op   = fu_op_e'(4'($urandom_range(12, 10)));
                        free = mult_free[l];
                    end
                    if (free) send(l, unit, op, $urandom, $urandom, -1);
                end
            end
            step();
        end
    endtask

    task automatic report(input int num, input string name);
        if (errors == err_before) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail with %0d errors", num, name, errors - err_before);
        end
        err_before = errors;
    endtask

    task automatic check_lane(input int l, input cdb_packet_t c);
        int t;
        t = int'(c.tag);
        if (flushed[t]) begin
            $display("tag %0d came out on cdb lane %0d after it was flushed", t, l);
            errors++;
        end else if (!busy[t]) begin
            $display("tag %0d came out on cdb lane %0d but was not outstanding", t, l);
            errors++;
        end else begin
            checks++;
            if (c.value !== expect_q[t].value) begin
                $display("** Error: cdb_o[%0d].value tag %0d: got %h, expected %h",
                         l, t, c.value, expect_q[t].value);
                errors++;
            end
            if (c.npc !== expect_q[t].npc) begin
                $display("** Error: cdb_o[%0d].npc tag %0d: got %h, expected %h",
                         l, t, c.npc, expect_q[t].npc);
                errors++;
            end
            if (c.halt !== expect_q[t].halt) begin
                $display("** Error: cdb_o[%0d].halt tag %0d: got %h, expected %h",
                         l, t, c.halt, expect_q[t].halt);
                errors++;
            end
            if (latency[t] >= 0 && cycle - issued_at[t] != latency[t]) begin
                $display("tag %0d came back %0d cycles after issue instead of %0d",
                         t, cycle - issued_at[t], latency[t]);
                errors++;
            end
            busy[t] = 1'b0;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clock) begin : compare
        if (reset === 1'b0) begin
            for (int l = 0; l < CDB_WIDTH; l++) begin
                if (cdb[l].valid === 1'b1) begin
                    check_lane(l, cdb[l]);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h7ef7));
        edge_a = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h80000000, 32'h12345678};
        edge_b = '{32'h0, 32'hffffffff, 32'hffffffff, 32'h1, 32'h1f, 32'hffffffe1};
        reset = 1'b1;
        clear = 1'b0;
        issue = '0;
        err_before  = 0;
        busy_cycles = 0;
        nflushed    = 0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        check_idle("after reset");
        report(1, "reset state");

        for (int op = 0; op < 10; op++) begin
            for (int k = 0; k < 9; k++) begin
                if (k < 6) send(k % 3, FU_ALU, fu_op_e'(4'(op)), edge_a[k], edge_b[k], 2);
                else send(k % 3, FU_ALU, fu_op_e'(4'(op)), $urandom, $urandom, 2);
                step();
                wait_drain("alu ops");
            end
        end
        report(2, "alu operations");

        for (int op = 10; op < 13; op++) begin
            for (int k = 0; k < 9; k++) begin
                if (k < 6) begin
                    send(k % 3, FU_MULT, fu_op_e'(4'(op)), edge_a[k], edge_b[k], MULT_STAGES + 1);
                end else begin
                    send(k % 3, FU_MULT, fu_op_e'(4'(op)), $urandom, $urandom, MULT_STAGES + 1);
                end
                step();
                wait_drain("multiplies");
            end
        end
        // a pipelined multiplier stays free while it fills
        for (int k = 0; k < MULT_STAGES; k++) begin
            if (mult_free[0] !== 1'b1) begin
                $display("multiplier 0 was not free for back to back multiply %0d", k);
                errors++;
            end
            send(0, FU_MULT, OP_MUL, $urandom, $urandom, MULT_STAGES + 1);
            step();
        end
        wait_drain("back to back multiplies");
        report(3, "multiplier operations");

        random_load(300);
        wait_drain("random load");
        if (busy_cycles == 0) begin
            $display("random load never made a unit busy");
            errors++;
        end
        report(4, "random mixed issue");

        random_load(40);
        clear = 1'b1;
        step();
        for (int t = 0; t < ROB_LEN; t++) begin
            if (busy[t]) begin
                busy[t]    = 1'b0;
                flushed[t] = 1'b1;
                nflushed++;
            end
        end
        clear = 1'b0;
        check_idle("after clear");
        repeat (20) step();
        send(0, FU_ALU, OP_ADD, $urandom, $urandom, 2);
        send(1, FU_MULT, OP_MULH, $urandom, $urandom, MULT_STAGES + 1);
        send(2, FU_ALU, OP_SRA, $urandom, $urandom, 2);
        step();
        wait_drain("issue after clear");
        for (int t = 0; t < ROB_LEN; t++) begin
            flushed[t] = 1'b0;
        end
        $display("clear flushed %0d results in flight", nflushed);
        report(5, "clear under load");

        $display("%0d results checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
    parameter int MULT_STAGES = 4,
    parameter int CDB_WIDTH   = 3
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 clear_i,
    input  issue_packet_t [ISSUE_WIDTH-1:0]      issue_i,
    output cdb_packet_t   [CDB_WIDTH-1:0]        cdb_o,
    output logic          [ISSUE_WIDTH-1:0]      alu_free_o,
    output logic          [ISSUE_WIDTH-1:0]      mult_free_o
);

    issue_packet_t [ISSUE_WIDTH-1:0] alu_issue;
    issue_packet_t [ISSUE_WIDTH-1:0] mult_issue;

    cdb_packet_t [ISSUE_WIDTH-1:0] alu_result;
    cdb_packet_t [ISSUE_WIDTH-1:0] mult_result;

    logic [ISSUE_WIDTH-1:0] alu_capture;
    logic [ISSUE_WIDTH-1:0] mult_capture;

    // lane i goes to alu i or mult i, the other unit sees an invalid packet
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            alu_issue[i]        = issue_i[i];
            alu_issue[i].valid  = issue_i[i].valid && (issue_i[i].unit == FU_ALU);
            mult_issue[i]       = issue_i[i];
            mult_issue[i].valid = issue_i[i].valid && (issue_i[i].unit == FU_MULT);
        end
    end

    genvar g;
    generate
        for (g = 0; g < ISSUE_WIDTH; g++) begin : g_lane
            alu_unit alu0 (
                .clock     (clock),
                .reset     (reset),
                .clear_i   (clear_i),
                .issue_i   (alu_issue[g]),
                .capture_i (alu_capture[g]),
                .result_o  (alu_result[g])
            );

            mult_unit #(
                .MULT_STAGES (MULT_STAGES)
            ) mult0 (
                .clock     (clock),
                .reset     (reset),
                .clear_i   (clear_i),
                .issue_i   (mult_issue[g]),
                .capture_i (mult_capture[g]),
                .result_o  (mult_result[g])
            );

            // a unit takes a new packet when its output is empty or leaving now
            assign alu_free_o[g]  = ~alu_result[g].valid | alu_capture[g];
            assign mult_free_o[g] = ~mult_result[g].valid | mult_capture[g];  // pipe not stalled
        end
    endgenerate

    complete_buffer #(
        .CDB_WIDTH (CDB_WIDTH)
    ) cbuf0 (
        .clock          (clock),
        .reset          (reset),
        .clear_i        (clear_i),
        .alu_result_i   (alu_result),
        .mult_result_i  (mult_result),
        .alu_capture_o  (alu_capture),
        .mult_capture_o (mult_capture),
        .cdb_o          (cdb_o)
    );

endmodule

//--- complete/complete_buffer.sv
`timescale 1ns/1ps

module complete_buffer import ex_pkg::*; #(
    parameter int CDB_WIDTH = 3
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               clear_i,
    input  cdb_packet_t [ISSUE_WIDTH-1:0]      alu_result_i,
    input  cdb_packet_t [ISSUE_WIDTH-1:0]      mult_result_i,
    output logic        [ISSUE_WIDTH-1:0]      alu_capture_o,
    output logic        [ISSUE_WIDTH-1:0]      mult_capture_o,
    output cdb_packet_t [CDB_WIDTH-1:0]        cdb_o
);

    cdb_packet_t [NUM_SLOTS-1:0] slot_q;
    cdb_packet_t [NUM_SLOTS-1:0] slot_next;
    cdb_packet_t [CDB_WIDTH-1:0] cdb_q;
    cdb_packet_t [CDB_WIDTH-1:0] cdb_next;

    // a unit's result moves in only when its own slot is empty
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            mult_capture_o[i] = mult_result_i[i].valid & ~slot_q[MULT_SLOT_BASE+i].valid;
            alu_capture_o[i]  = alu_result_i[i].valid & ~slot_q[ALU_SLOT_BASE+i].valid;
        end
    end

    always_comb begin
        int lane;

        // slots after capture
        slot_next = slot_q;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (mult_capture_o[i]) begin
                slot_next[MULT_SLOT_BASE+i] = mult_result_i[i];
            end
            if (alu_capture_o[i]) begin
                slot_next[ALU_SLOT_BASE+i] = alu_result_i[i];
            end
        end

        // lowest occupied slots win the cdb lanes
        // no age order, a slot left out just tries again next cycle
        cdb_next = '0;
        lane     = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (slot_next[s].valid && lane < CDB_WIDTH) begin
                cdb_next[lane]     = slot_next[s];
                slot_next[s].valid = 1'b0;  // leaves the buffer this cycle
                lane++;
            end
        end
    end

    always_ff @(posedge clock) begin
        slot_q <= slot_next;
        cdb_q  <= cdb_next;
        if (reset || clear_i) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                slot_q[s].valid <= 1'b0;
            end
            for (int l = 0; l < CDB_WIDTH; l++) begin
                cdb_q[l].valid <= 1'b0;
            end
        end
    end

    assign cdb_o = cdb_q;  // registered cdb

endmodule

//--- mult/mult_unit.sv
`timescale 1ns/1ps

module mult_unit import ex_pkg::*; #(
    parameter int MULT_STAGES = 4
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          clear_i,
    input  issue_packet_t issue_i,
    input  logic          capture_i,
    output cdb_packet_t   result_o
);

    // one pipe stage, full product plus what the cdb needs
    typedef struct packed {
        logic              valid;
        logic              high;  // take upper word at the end
        tag_t              tag;
        logic [2*XLEN-1:0] prod;
        xlen_t             npc;
        logic              halt;
    } stage_t;

    stage_t            stage_q [MULT_STAGES];
    stage_t            entry;
    stage_t            last;
    logic              sign_ext;
    logic [2*XLEN-1:0] opa_ext;
    logic [2*XLEN-1:0] opb_ext;
    logic              advance;

    // mulh is signed, mul and mulhu can use the zero extended form
    assign sign_ext = (issue_i.op == OP_MULH);
    assign opa_ext  = {{XLEN{sign_ext & issue_i.opa[XLEN-1]}}, issue_i.opa};
    assign opb_ext  = {{XLEN{sign_ext & issue_i.opb[XLEN-1]}}, issue_i.opb};

    always_comb begin
        entry.valid = issue_i.valid;
        entry.high  = (issue_i.op != OP_MUL);
        entry.tag   = issue_i.tag;
        entry.prod  = opa_ext * opb_ext;  // low 2*XLEN bits are exact
        entry.npc   = issue_i.npc;
        entry.halt  = issue_i.halt;
    end

    assign last = stage_q[MULT_STAGES-1];

    // whole pipe stalls while the result waits for a slot
    assign advance = ~last.valid | capture_i;

    always_ff @(posedge clock) begin
        if (advance) begin
            stage_q[0] <= entry;
            for (int s = 1; s < MULT_STAGES; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
        if (reset || clear_i) begin
            for (int s = 0; s < MULT_STAGES; s++) begin
                stage_q[s].valid <= 1'b0;
            end
        end
    end

    // word select on the way out
    always_comb begin
        result_o.valid = last.valid;
        result_o.tag   = last.tag;
        result_o.value = last.high ? last.prod[2*XLEN-1:XLEN] : last.prod[XLEN-1:0];
        result_o.npc   = last.npc;
        result_o.halt  = last.halt;
    end

endmodule

//--- design/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import ex_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          clear_i,
    input  issue_packet_t issue_i,
    input  logic          capture_i,
    output cdb_packet_t   result_o
);

    cdb_packet_t result_q;
    xlen_t       alu_value;
    logic [4:0]  shamt;
    logic        load;

    assign shamt = issue_i.opb[4:0];  // rv32 shift amount

    always_comb begin
        case (issue_i.op)
            OP_ADD:  alu_value = issue_i.opa + issue_i.opb;
            OP_SUB:  alu_value = issue_i.opa - issue_i.opb;
            OP_AND:  alu_value = issue_i.opa & issue_i.opb;
            OP_OR:   alu_value = issue_i.opa | issue_i.opb;
            OP_XOR:  alu_value = issue_i.opa ^ issue_i.opb;
            OP_SLT: begin
                alu_value = {{(XLEN-1){1'b0}}, $signed(issue_i.opa) < $signed(issue_i.opb)};
            end
            OP_SLTU: begin
                alu_value = {{(XLEN-1){1'b0}}, issue_i.opa < issue_i.opb};
            end
            OP_SLL:  alu_value = issue_i.opa << shamt;
            OP_SRL:  alu_value = issue_i.opa >> shamt;
            OP_SRA:  alu_value = xlen_t'($signed(issue_i.opa) >>> shamt);
            default: alu_value = '0;  // mult ops never reach here
        endcase
    end

    // hold the result until the complete buffer takes it
    assign load = ~result_q.valid | capture_i;

    always_ff @(posedge clock) begin
        if (load) begin
            result_q.valid <= issue_i.valid;
            result_q.tag   <= issue_i.tag;
            result_q.value <= alu_value;
            result_q.npc   <= issue_i.npc;
            result_q.halt  <= issue_i.halt;
        end
        if (reset || clear_i) begin
            result_q.valid <= 1'b0;  // flush, payload kept
        end
    end

    assign result_o = result_q;

endmodule

//--- common/ex_pkg.sv
package ex_pkg;

    // datapath widths
    localparam int XLEN    = 32;
    localparam int ROB_LEN = 32;
    localparam int TAG_W   = $clog2(ROB_LEN);

    // lane i feeds alu i and mult i
    localparam int ISSUE_WIDTH = 3;

    // complete buffer layout, mults first then alus
    localparam int NUM_SLOTS      = 2 * ISSUE_WIDTH;
    localparam int MULT_SLOT_BASE = 0;
    localparam int ALU_SLOT_BASE  = ISSUE_WIDTH;

    typedef logic [TAG_W-1:0] tag_t;  // rob index
    typedef logic [XLEN-1:0]  xlen_t;

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } func_unit_e;

    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_SLT   = 4'h5,
        OP_SLTU  = 4'h6,
        OP_SLL   = 4'h7,
        OP_SRL   = 4'h8,
        OP_SRA   = 4'h9,
        // multiplier ops
        OP_MUL   = 4'ha,  // low word
        OP_MULH  = 4'hb,  // high word, signed x signed
        OP_MULHU = 4'hc   // high word, unsigned x unsigned
    } fu_op_e;

    // one instruction out of the reservation stations, operands already read
    typedef struct packed {
        logic       valid;
        func_unit_e unit;
        fu_op_e     op;
        tag_t       tag;
        xlen_t      opa;
        xlen_t      opb;
        xlen_t      npc;
        logic       halt;
    } issue_packet_t;

    // finished result, unit output and cdb lane
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        xlen_t value;
        xlen_t npc;
        logic  halt;
    } cdb_packet_t;

endpackage
